// File: verilog/scratch_config.svh
`ifndef SCRATCH_CONFIG_SVH
`define SCRATCH_CONFIG_SVH

// Word address width, 256 words
`define SCRATCH_ADDR_W 8

// Word width in bits
`define SCRATCH_DATA_W 16

// 1 adds a second register on both RAM read outputs
`define SCRATCH_REG_OUT 1

// Read port during a write of the same port
// 1 returns the write data, 0 returns the old memory word
`define SCRATCH_RD_WR_DATA 1

// Address sample to read data valid, in clock edges
`define SCRATCH_RD_LAT (1 + `SCRATCH_REG_OUT)

`endif

// File: verilog/scratch_pkg.sv
`include "scratch_config.svh"

package scratch_pkg;

	// One memory word
	typedef logic [`SCRATCH_DATA_W-1:0] word_t;

	// One word address
	typedef logic [`SCRATCH_ADDR_W-1:0] addr_t;

	// Arbiter grant state
	// NONE means the shared slave is free for a new decision
	typedef enum logic [1:0] {
		NONE = 2'd0,  // Idle, nobody owns port A
		M0   = 2'd1,  // Master 0 owns port A
		M1   = 2'd2   // Master 1 owns port A
	} grant_t;

endpackage

// File: verilog/wb_if.sv
// Wishbone classic bundle, full words only
// Request held by master until ack is seen high
interface wb_if import scratch_pkg::*; ();

	logic  cyc;    // Bus cycle in progress
	logic  stb;    // Strobe, valid transfer
	logic  we;     // 1 write, 0 read
	addr_t adr;    // Word address
	word_t dat_w;  // Master to slave data
	word_t dat_r;  // Slave to master data, valid with ack on reads
	logic  ack;    // Single-cycle transfer done

	// Requesting side
	modport master (
		output cyc,
		output stb,
		output we,
		output adr,
		output dat_w,
		input  dat_r,
		input  ack
	);

	// Responding side
	modport slave (
		input  cyc,
		input  stb,
		input  we,
		input  adr,
		input  dat_w,
		output dat_r,
		output ack
	);

endinterface

// File: verilog/dp_ram_infer.sv
`include "scratch_config.svh"

// Two-port synchronous RAM, both ports on one clock
// Written so synthesis maps it onto a true dual port block RAM
module dp_ram_infer import scratch_pkg::*; (
	input  logic  a_clk_i,   // Common clock for both ports
	// Port A
	input  addr_t a_addr_i,  // A word address
	input  logic  a_wr_i,    // A write enable, active high
	input  word_t a_data_i,  // A write data
	output word_t a_data_o,  // A read data
	// Port B
	input  addr_t b_addr_i,  // B word address
	input  logic  b_wr_i,    // B write enable, active high
	input  word_t b_data_i,  // B write data
	output word_t b_data_o   // B read data
);

	localparam int unsigned DEPTH = 2 ** `SCRATCH_ADDR_W;  // Words in the array

	word_t ram [0:DEPTH-1];  // Storage, contents undefined at power-up
	word_t a_data;           // First read stage, port A
	word_t b_data;           // First read stage, port B

	// Both write ports in one process
	// Same address from both ports in one cycle is left undefined
	always_ff @(posedge a_clk_i) begin
		if (a_wr_i) begin
			ram[a_addr_i] <= a_data_i;
		end
		if (b_wr_i) begin
			ram[b_addr_i] <= b_data_i;
		end
	end

	// Port A read, mode picks new or old word on a write
	always_ff @(posedge a_clk_i) begin
		if (a_wr_i && (`SCRATCH_RD_WR_DATA != 0)) begin
			a_data <= a_data_i;  // Write-through
		end else begin
			a_data <= ram[a_addr_i];
		end
	end

	// Port B read, same rule
	always_ff @(posedge a_clk_i) begin
		if (b_wr_i && (`SCRATCH_RD_WR_DATA != 0)) begin
			b_data <= b_data_i;
		end else begin
			b_data <= ram[b_addr_i];
		end
	end

	// Extra output stage, usually the BRAM's own output register
	generate
		if (`SCRATCH_REG_OUT != 0) begin : g_reg_out
			word_t a_data_q;  // Second stage, A
			word_t b_data_q;  // Second stage, B
			always_ff @(posedge a_clk_i) begin
				a_data_q <= a_data;
				b_data_q <= b_data;
			end
			assign a_data_o = a_data_q;
			assign b_data_o = b_data_q;
		end else begin : g_no_reg
			assign a_data_o = a_data;  // Single stage latency
			assign b_data_o = b_data;
		end
	endgenerate

endmodule

// File: verilog/wb_ram_port.sv
`include "scratch_config.svh"

// Wishbone classic slave in front of one RAM port
// One access in flight, ack timed to the RAM read latency
module wb_ram_port import scratch_pkg::*; (
	input  logic  a_clk_i,     // Clock
	input  logic  rst_n_i,     // Async reset, active low
	wb_if.slave   bus,         // Bus from master or arbiter
	output addr_t ram_addr_o,  // RAM address
	output logic  ram_wr_o,    // RAM write enable
	output word_t ram_data_o,  // RAM write data
	input  word_t ram_data_i   // RAM read data
);

	localparam int unsigned RD_LAT = `SCRATCH_RD_LAT;  // Edges to read data

	logic       busy;   // Access issued, ack not yet given
	logic [1:0] cnt;    // Cycles left until ack
	logic       we_q;   // Kind of the access in flight
	logic       issue;  // New access goes to the RAM this edge

	// Held stb in the ack cycle is blocked by busy
	assign issue = bus.cyc && bus.stb && !busy;

	// Access goes straight to the RAM, sampled on the issue edge
	assign ram_addr_o = bus.adr;
	assign ram_wr_o   = issue && bus.we;  // Only one write per cycle
	assign ram_data_o = bus.dat_w;

	// Busy flag and latency countdown
	always_ff @(posedge a_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy <= 1'b0;
			cnt  <= 2'd0;
			we_q <= 1'b0;
		end else if (issue) begin
			busy <= 1'b1;
			we_q <= bus.we;
			// Write acks next cycle, read waits for the data
			if (bus.we) begin
				cnt <= 2'd0;
			end else begin
				cnt <= 2'(RD_LAT - 1);
			end
		end else if (busy) begin
			if (cnt == 2'd0) begin
				busy <= 1'b0;  // Ack cycle ends the access
			end else begin
				cnt <= cnt - 2'd1;
			end
		end
	end

	// Ack from registers only, one cycle wide
	assign bus.ack = busy && (cnt == 2'd0);

	// Read data passes through, port output during a write is dropped
	assign bus.dat_r = we_q ? '0 : ram_data_i;

endmodule

// File: verilog/wb_rr_arbiter.sv
// Two Wishbone masters sharing one slave
// Registered grant, round-robin on ties, held until the forwarded ack
module wb_rr_arbiter import scratch_pkg::*; (
	input  logic a_clk_i,  // Clock
	input  logic rst_n_i,  // Async reset, active low
	wb_if.slave  m0,       // Master 0 side
	wb_if.slave  m1,       // Master 1 side
	wb_if.master s         // Shared slave side
);

	grant_t grant;    // Current owner of the slave
	logic   last_m1;  // 1 when m1 was served last
	logic   req0;     // Master 0 wants the bus
	logic   req1;     // Master 1 wants the bus

	assign req0 = m0.cyc && m0.stb;
	assign req1 = m1.cyc && m1.stb;

	// Grant state
	// Decide only when idle, release on the ack of the owner
	always_ff @(posedge a_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			grant   <= NONE;
			last_m1 <= 1'b1;  // m0 wins the first tie
		end else begin
			case (grant)
				NONE: begin
					if (req0 && (!req1 || last_m1)) begin
						grant <= M0;
					end else if (req1) begin
						grant <= M1;
					end
				end
				M0: begin
					if (s.ack) begin
						grant   <= NONE;
						last_m1 <= 1'b0;
					end
				end
				M1: begin
					if (s.ack) begin
						grant   <= NONE;
						last_m1 <= 1'b1;
					end
				end
				default: begin
					grant <= NONE;  // Unused encoding
				end
			endcase
		end
	end

	// Request mux toward the slave
	always_comb begin
		s.cyc   = 1'b0;
		s.stb   = 1'b0;
		s.we    = 1'b0;
		s.adr   = m0.adr;
		s.dat_w = m0.dat_w;
		case (grant)
			M0: begin
				s.cyc   = m0.cyc;
				s.stb   = m0.stb;
				s.we    = m0.we;
				s.adr   = m0.adr;
				s.dat_w = m0.dat_w;
			end
			M1: begin
				s.cyc   = m1.cyc;
				s.stb   = m1.stb;
				s.we    = m1.we;
				s.adr   = m1.adr;
				s.dat_w = m1.dat_w;
			end
			default: begin
				s.cyc = 1'b0;  // Idle, nothing forwarded
			end
		endcase
	end

	// Responses go back to the owner only, the other one waits
	assign m0.ack   = (grant == M0) && s.ack;
	assign m0.dat_r = (grant == M0) ? s.dat_r : '0;
	assign m1.ack   = (grant == M1) && s.ack;
	assign m1.dat_r = (grant == M1) ? s.dat_r : '0;

endmodule

// File: verilog/scratch_top.sv
// Shared scratchpad
// m0 and m1 share RAM port A through the arbiter, m2 owns port B
module scratch_top import scratch_pkg::*; (
	input  logic  a_clk_i,    // Single clock for all ports
	input  logic  rst_n_i,    // Async reset, active low
	// Master 0, arbitrated
	input  logic  m0_cyc_i,
	input  logic  m0_stb_i,
	input  logic  m0_we_i,
	input  addr_t m0_adr_i,
	input  word_t m0_dat_i,
	output word_t m0_dat_o,
	output logic  m0_ack_o,
	// Master 1, arbitrated
	input  logic  m1_cyc_i,
	input  logic  m1_stb_i,
	input  logic  m1_we_i,
	input  addr_t m1_adr_i,
	input  word_t m1_dat_i,
	output word_t m1_dat_o,
	output logic  m1_ack_o,
	// Master 2, direct to port B
	input  logic  m2_cyc_i,
	input  logic  m2_stb_i,
	input  logic  m2_we_i,
	input  addr_t m2_adr_i,
	input  word_t m2_dat_i,
	output word_t m2_dat_o,
	output logic  m2_ack_o
);

	wb_if m0_bus ();  // Master 0 to arbiter
	wb_if m1_bus ();  // Master 1 to arbiter
	wb_if m2_bus ();  // Master 2 to port B adapter
	wb_if pa_bus ();  // Arbiter to port A adapter, owner per grant_t

	addr_t a_addr;   // RAM port A
	logic  a_wr;
	word_t a_wdata;
	word_t a_rdata;
	addr_t b_addr;   // RAM port B
	logic  b_wr;
	word_t b_wdata;
	word_t b_rdata;

	// Plain ports onto the bundles
	assign m0_bus.cyc   = m0_cyc_i;
	assign m0_bus.stb   = m0_stb_i;
	assign m0_bus.we    = m0_we_i;
	assign m0_bus.adr   = m0_adr_i;
	assign m0_bus.dat_w = m0_dat_i;
	assign m0_dat_o     = m0_bus.dat_r;
	assign m0_ack_o     = m0_bus.ack;

	assign m1_bus.cyc   = m1_cyc_i;
	assign m1_bus.stb   = m1_stb_i;
	assign m1_bus.we    = m1_we_i;
	assign m1_bus.adr   = m1_adr_i;
	assign m1_bus.dat_w = m1_dat_i;
	assign m1_dat_o     = m1_bus.dat_r;
	assign m1_ack_o     = m1_bus.ack;

	assign m2_bus.cyc   = m2_cyc_i;
	assign m2_bus.stb   = m2_stb_i;
	assign m2_bus.we    = m2_we_i;
	assign m2_bus.adr   = m2_adr_i;
	assign m2_bus.dat_w = m2_dat_i;
	assign m2_dat_o     = m2_bus.dat_r;
	assign m2_ack_o     = m2_bus.ack;

	// Grant NONE after reset, m0 first on a tie
	wb_rr_arbiter u_arb (.a_clk_i(a_clk_i), .rst_n_i(rst_n_i),
		.m0(m0_bus), .m1(m1_bus), .s(pa_bus));

	wb_ram_port u_port_a (.a_clk_i(a_clk_i), .rst_n_i(rst_n_i), .bus(pa_bus),
		.ram_addr_o(a_addr), .ram_wr_o(a_wr), .ram_data_o(a_wdata), .ram_data_i(a_rdata));

	wb_ram_port u_port_b (.a_clk_i(a_clk_i), .rst_n_i(rst_n_i), .bus(m2_bus),
		.ram_addr_o(b_addr), .ram_wr_o(b_wr), .ram_data_o(b_wdata), .ram_data_i(b_rdata));

	dp_ram_infer u_ram (
		.a_clk_i (a_clk_i),
		.a_addr_i(a_addr),
		.a_wr_i  (a_wr),
		.a_data_i(a_wdata),
		.a_data_o(a_rdata),
		.b_addr_i(b_addr),
		.b_wr_i  (b_wr),
		.b_data_i(b_wdata),
		.b_data_o(b_rdata)
	);

endmodule

// File: tb/tb_scratch.sv
// Scratchpad testbench
// Three Wishbone masters, shadow memory, table and LFSR driven traffic
module tb_scratch import scratch_pkg::*; ;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned TIMEOUT   = 50;                // Cycles per ack wait
	localparam int unsigned NSTEPS    = 8;                 // Directed table rows
	localparam int unsigned NPAIRS    = 20;                // Random pairs, 40 accesses
	localparam int unsigned RND_ADR_W = 4;                 // Random window, reads hit written words
	localparam int unsigned DEPTH     = 2 ** $bits(addr_t);
	localparam logic [31:0] LFSR_MASK = 32'h80200003;      // Taps 32 22 2 1

	// One directed access
	typedef struct packed {
		logic [1:0] mst;  // 0 and 1 arbitrated, 2 on port B
		logic       we;
		addr_t      adr;
		word_t      dat;
		word_t      exp;  // Read result, unused on writes
	} step_t;

	logic  clk;
	logic  rst_n;
	logic  m0_cyc;
	logic  m0_stb;
	logic  m0_we;
	addr_t m0_adr;
	word_t m0_dat;
	word_t m0_rdat;
	logic  m0_ack;
	logic  m1_cyc;
	logic  m1_stb;
	logic  m1_we;
	addr_t m1_adr;
	word_t m1_dat;
	word_t m1_rdat;
	logic  m1_ack;
	logic  m2_cyc;
	logic  m2_stb;
	logic  m2_we;
	addr_t m2_adr;
	word_t m2_dat;
	word_t m2_rdat;
	logic  m2_ack;

	word_t       shadow [0:DEPTH-1];  // Expected memory contents
	bit          known [0:DEPTH-1];   // Word written at least once
	step_t       steps [0:NSTEPS-1];
	logic [31:0] lfsr;
	logic        last_m1;             // Arbiter pointer model, m1 served last
	int unsigned cyc_cnt = 0;
	int unsigned errors;
	int unsigned timeouts;

	scratch_top dut0 (
		.a_clk_i(clk), .rst_n_i(rst_n),
		.m0_cyc_i(m0_cyc), .m0_stb_i(m0_stb), .m0_we_i(m0_we), .m0_adr_i(m0_adr),
		.m0_dat_i(m0_dat), .m0_dat_o(m0_rdat), .m0_ack_o(m0_ack),
		.m1_cyc_i(m1_cyc), .m1_stb_i(m1_stb), .m1_we_i(m1_we), .m1_adr_i(m1_adr),
		.m1_dat_i(m1_dat), .m1_dat_o(m1_rdat), .m1_ack_o(m1_ack),
		.m2_cyc_i(m2_cyc), .m2_stb_i(m2_stb), .m2_we_i(m2_we), .m2_adr_i(m2_adr),
		.m2_dat_i(m2_dat), .m2_dat_o(m2_rdat), .m2_ack_o(m2_ack)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns period
	end

	always @(posedge clk) cyc_cnt <= cyc_cnt + 1;  // Orders acks of parallel masters

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] draw(input int unsigned n);
		logic [31:0] v;
		int unsigned i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_MASK : 32'h0);
		end
		return v;
	endfunction

	// Ack polled mid-cycle where DUT outputs are settled
	task automatic wait_ack(input int unsigned m, output word_t rdat, output int unsigned at_cyc);
		int unsigned waited;
		logic        got;
		logic        ack;
		waited = 0;
		got    = 1'b0;
		rdat   = '0;
		at_cyc = 0;
		while (!got && waited < TIMEOUT) begin
			@(negedge clk);
			case (m)
				0: ack = m0_ack;
				1: ack = m1_ack;
				default: ack = m2_ack;
			endcase
			if (ack) begin
				got    = 1'b1;
				rdat   = (m == 0) ? m0_rdat : ((m == 1) ? m1_rdat : m2_rdat);
				at_cyc = cyc_cnt;
			end else begin
				waited++;
			end
		end
		if (!got) begin
			timeouts++;
			$display("Timeout at %0t: m%0d saw no ack within %0d cycles", $time, m, TIMEOUT);
		end
	endtask

	task automatic m0_transfer(input logic we, input addr_t adr, input word_t dat,
			output word_t rdat, output int unsigned at_cyc);
		@(posedge clk);
		#1;
		m0_cyc = 1'b1;
		m0_stb = 1'b1;
		m0_we  = we;
		m0_adr = adr;
		m0_dat = dat;
		wait_ack(0, rdat, at_cyc);
		@(posedge clk);
		#1;
		m0_cyc = 1'b0;  // Cycle over after the ack edge
		m0_stb = 1'b0;
		m0_we  = 1'b0;
	endtask

	task automatic m1_transfer(input logic we, input addr_t adr, input word_t dat,
			output word_t rdat, output int unsigned at_cyc);
		@(posedge clk);
		#1;
		m1_cyc = 1'b1;
		m1_stb = 1'b1;
		m1_we  = we;
		m1_adr = adr;
		m1_dat = dat;
		wait_ack(1, rdat, at_cyc);
		@(posedge clk);
		#1;
		m1_cyc = 1'b0;
		m1_stb = 1'b0;
		m1_we  = 1'b0;
	endtask

	task automatic m2_transfer(input logic we, input addr_t adr, input word_t dat,
			output word_t rdat, output int unsigned at_cyc);
		@(posedge clk);
		#1;
		m2_cyc = 1'b1;  // Port B, never contended
		m2_stb = 1'b1;
		m2_we  = we;
		m2_adr = adr;
		m2_dat = dat;
		wait_ack(2, rdat, at_cyc);
		@(posedge clk);
		#1;
		m2_cyc = 1'b0;
		m2_stb = 1'b0;
		m2_we  = 1'b0;
	endtask

	// Single access on any master, pointer model follows port A owners
	task automatic run_access(input logic [1:0] m, input logic we, input addr_t adr,
			input word_t dat, output word_t rdat, output int unsigned at_cyc);
		case (m)
			2'd0: begin
				m0_transfer(we, adr, dat, rdat, at_cyc);
				last_m1 = 1'b0;
			end
			2'd1: begin
				m1_transfer(we, adr, dat, rdat, at_cyc);
				last_m1 = 1'b1;
			end
			default: m2_transfer(we, adr, dat, rdat, at_cyc);
		endcase
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		assert (act === exp) else begin
			errors++;
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic note_write(input addr_t adr, input word_t dat);
		shadow[adr] = dat;
		known[adr]  = 1'b1;
	endtask

	// m0 and m1 raise their requests on the same edge
	task automatic tie_round(input logic we, input addr_t a0, input word_t d0,
			input addr_t a1, input word_t d1);
		word_t       r0;
		word_t       r1;
		word_t       e0;
		word_t       e1;
		int unsigned c0;
		int unsigned c1;
		logic        win_m1;
		e0     = shadow[a0];
		e1     = shadow[a1];
		win_m1 = !last_m1;  // Master not served last wins
		fork
			m0_transfer(we, a0, d0, r0, c0);
			m1_transfer(we, a1, d1, r1, c1);
		join
		assert (win_m1 ? (c1 < c0) : (c0 < c1)) else begin
			errors++;
			$display("Wrong arbitration order at %0t: m%0d was not acked first",
				$time, win_m1 ? 1 : 0);
		end
		last_m1 = !win_m1;  // Loser goes second
		if (we) begin
			note_write(a0, d0);
			note_write(a1, d1);
		end else begin
			check_word("m0_dat_o", e0, r0);
			check_word("m1_dat_o", e1, r1);
		end
	endtask

	// Port A and port B traffic in parallel, addresses kept apart
	task automatic random_pairs();
		logic [1:0]  am;
		logic        a_we;
		logic        b_we;
		addr_t       a_adr;
		addr_t       b_adr;
		word_t       a_dat;
		word_t       b_dat;
		word_t       a_exp;
		word_t       b_exp;
		word_t       a_rd;
		word_t       b_rd;
		int unsigned a_cyc;
		int unsigned b_cyc;
		int unsigned k;
		for (k = 0; k < NPAIRS; k++) begin
			am    = 2'(draw(1));  // m0 or m1
			a_we  = 1'(draw(1));
			a_adr = addr_t'(draw(RND_ADR_W));
			a_dat = word_t'(draw($bits(word_t)));
			b_we  = 1'(draw(1));
			b_adr = addr_t'(draw(RND_ADR_W));
			b_dat = word_t'(draw($bits(word_t)));
			if (b_adr == a_adr) b_adr = b_adr ^ addr_t'(1);
			if (!known[a_adr]) a_we = 1'b1;  // No reads of undefined words
			if (!known[b_adr]) b_we = 1'b1;
			a_exp = shadow[a_adr];
			b_exp = shadow[b_adr];
			fork
				run_access(am, a_we, a_adr, a_dat, a_rd, a_cyc);
				m2_transfer(b_we, b_adr, b_dat, b_rd, b_cyc);
			join
			if (a_we) note_write(a_adr, a_dat);
			else check_word($sformatf("m%0d_dat_o", am), a_exp, a_rd);
			if (b_we) note_write(b_adr, b_dat);
			else check_word("m2_dat_o", b_exp, b_rd);
		end
	endtask

	initial begin
		int unsigned i;
		word_t       rdat;
		int unsigned at_cyc;
		lfsr     = 32'hdaee;
		errors   = 0;
		timeouts = 0;
		last_m1  = 1'b1;  // Reset pointer, m0 wins first tie
		rst_n    = 1'b0;
		{m0_cyc, m0_stb, m0_we, m0_adr, m0_dat} = '0;
		{m1_cyc, m1_stb, m1_we, m1_adr, m1_dat} = '0;
		{m2_cyc, m2_stb, m2_we, m2_adr, m2_dat} = '0;
		for (i = 0; i < DEPTH; i++) known[i] = 1'b0;
		// Columns: master, we, address, data, expected read
		steps[0] = '{2'd0, 1'b1, 8'h10, 16'h1234, 16'h0000};  // m0 write then read
		steps[1] = '{2'd0, 1'b0, 8'h10, 16'h0000, 16'h1234};
		steps[2] = '{2'd1, 1'b1, 8'h20, 16'hbeef, 16'h0000};  // m1 to m0
		steps[3] = '{2'd0, 1'b0, 8'h20, 16'h0000, 16'hbeef};
		steps[4] = '{2'd2, 1'b1, 8'h30, 16'h5a5a, 16'h0000};  // Port B to port A
		steps[5] = '{2'd0, 1'b0, 8'h30, 16'h0000, 16'h5a5a};
		steps[6] = '{2'd0, 1'b1, 8'h40, 16'hc3c3, 16'h0000};  // Port A to port B
		steps[7] = '{2'd2, 1'b0, 8'h40, 16'h0000, 16'hc3c3};
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		tie_round(1'b1, 8'h01, 16'haaaa, 8'h02, 16'h5555);  // First tie after reset
		for (i = 0; i < NSTEPS; i++) begin
			run_access(steps[i].mst, steps[i].we, steps[i].adr, steps[i].dat, rdat, at_cyc);
			if (steps[i].we) note_write(steps[i].adr, steps[i].dat);
			else check_word($sformatf("m%0d_dat_o", steps[i].mst), steps[i].exp, rdat);
		end
		tie_round(1'b0, 8'h02, 16'h0000, 8'h01, 16'h0000);  // m0 served last, m1 wins
		random_pairs();
		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+verilog
verilog/scratch_pkg.sv
verilog/wb_if.sv
verilog/dp_ram_infer.sv
verilog/wb_ram_port.sv
verilog/wb_rr_arbiter.sv
verilog/scratch_top.sv
tb/tb_scratch.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f vlog.f --top-module tb_scratch -Mdir obj_dir -o sim_scratch > build.log 2>&1 \
	&& ./obj_dir/sim_scratch > sim.log 2>&1 \
	&& grep -q "Test passed" sim.log \
	&& echo "Simulation PASS" \
	|| { echo "Simulation FAIL, see build.log and sim.log"; exit 1; }
